// ==== common/rvcore_macros.svh ====
`ifndef RVCORE_MACROS_SVH
`define RVCORE_MACROS_SVH

// datapath sizing
`define XLEN 32
`define REG_COUNT 32
`define RESET_PC 32'h0000_0000

// alu control codes
`define ALU_ADD 4'b0000
`define ALU_SUB 4'b0001
`define ALU_AND 4'b0010
`define ALU_OR 4'b0011
`define ALU_SLL 4'b0100
`define ALU_SLT 4'b0101
`define ALU_SRL 4'b0110
`define ALU_SRA 4'b0111
`define ALU_BCMP 4'b1000 // signed less-than, used by bge
`define ALU_XOR 4'b1001
`define ALU_PASSB 4'b1111

// rv32i opcodes
`define OP_LUI 7'b0110111
`define OP_OPIMM 7'b0010011
`define OP_OP 7'b0110011
`define OP_LOAD 7'b0000011
`define OP_STORE 7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL 7'b1101111

`endif

// ==== common/rvcore_pkg.sv ====
package rvcore_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFormat;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFormat;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormat;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFormat;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uFormat;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jFormat;

    // one fetched word, seen through each encoding format
    typedef union packed {
        rFormat R;
        iFormat I;
        sFormat S;
        bFormat B;
        uFormat U;
        jFormat J;
    } instrWord;

    typedef enum logic [1:0] {
        opMemAdd    = 2'b00, // address calc for loads and stores
        opBranchCmp = 2'b01,
        opFunct     = 2'b10, // decoded from funct3 / funct7
        opPassB     = 2'b11
    } aluOpClass;

    typedef enum logic [1:0] {
        dtWord  = 2'b00,
        dtByteU = 2'b01,
        dtHalfU = 2'b10
    } dataType;

    typedef enum logic [2:0] {
        immI = 3'b000,
        immS = 3'b001,
        immB = 3'b010,
        immU = 3'b011,
        immJ = 3'b100
    } immSel;

    typedef enum logic [1:0] {
        resAlu     = 2'b00,
        resLoad    = 2'b01,
        resPcPlus4 = 2'b10
    } resultSel;

endpackage

// ==== common/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrlIf import rvcore_pkg::*; ();

    logic       regWrite;
    logic       aluSrcImm; // b operand from immediate
    logic       memWrite;
    resultSel   resultSrc;
    immSel      immSrc;
    logic [3:0] aluControl;
    dataType    loadType;
    logic       pcSrc;     // take pc + imm

    modport source (
        output regWrite, aluSrcImm, memWrite, resultSrc,
        output immSrc, aluControl, loadType, pcSrc
    );

    modport sink (
        input regWrite, aluSrcImm, memWrite, resultSrc,
        input immSrc, aluControl, loadType, pcSrc
    );

endinterface

// ==== control/mainDecoder.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module mainDecoder import rvcore_pkg::*; (
    input  instrWord  instr,
    output logic      regWrite,
    output logic      aluSrcImm,
    output logic      memWrite,
    output logic      branch,
    output logic      jump,
    output resultSel  resultSrc,
    output immSel     immSrc,
    output aluOpClass aluOp
);

    always_comb begin
        regWrite  = 1'b0; // unknown opcodes write nothing
        aluSrcImm = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        resultSrc = resAlu;
        immSrc    = immI;
        aluOp     = opMemAdd;
        case (instr.R.opcode)
            `OP_LUI: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSrc    = immU;
                aluOp     = opPassB; // upper immediate straight through
            end
            `OP_OPIMM: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                aluOp     = opFunct;
            end
            `OP_OP: begin
                regWrite = 1'b1;
                aluOp    = opFunct;
            end
            `OP_LOAD: begin
                regWrite  = 1'b1;
                aluSrcImm = 1'b1;
                resultSrc = resLoad;
            end
            `OP_STORE: begin
                memWrite  = 1'b1;
                aluSrcImm = 1'b1;
                immSrc    = immS;
            end
            `OP_BRANCH: begin
                branch = 1'b1;
                immSrc = immB;
                aluOp  = opBranchCmp;
            end
            `OP_JAL: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                immSrc    = immJ;
                resultSrc = resPcPlus4; // link value
            end
            default: ;
        endcase
    end

endmodule

// ==== control/aluDecoder.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module aluDecoder import rvcore_pkg::*; (
    input  logic       op5,     // set for register-register ops
    input  logic       funct75,
    input  logic [2:0] funct3,
    input  aluOpClass  aluOp,
    output logic [3:0] aluControl,
    output dataType    loadType
);

    always_comb begin
        aluControl = `ALU_ADD;
        loadType   = dtWord;
        case (aluOp)
            opMemAdd: begin
                aluControl = `ALU_ADD; // base + offset
                case (funct3)
                    3'b010:  loadType = dtWord;
                    3'b100:  loadType = dtByteU;
                    3'b101:  loadType = dtHalfU;
                    default: loadType = dtWord;
                endcase
            end
            opBranchCmp: begin
                case (funct3)
                    3'b000:  aluControl = `ALU_SUB;  // beq
                    3'b101:  aluControl = `ALU_BCMP; // bge
                    default: aluControl = `ALU_SUB;
                endcase
            end
            opFunct: begin
                case (funct3)
                    3'b000: begin
                        // addi with imm bit 10 set must stay an add
                        if (funct75 && op5)
                            aluControl = `ALU_SUB;
                        else
                            aluControl = `ALU_ADD;
                    end
                    3'b001: aluControl = `ALU_SLL;
                    3'b010: aluControl = `ALU_SLT;
                    3'b100: aluControl = `ALU_XOR;
                    3'b101: begin
                        if (funct75)
                            aluControl = `ALU_SRA; // srai too
                        else
                            aluControl = `ALU_SRL;
                    end
                    3'b110:  aluControl = `ALU_OR;
                    3'b111:  aluControl = `ALU_AND;
                    default: aluControl = `ALU_ADD;
                endcase
            end
            opPassB: aluControl = `ALU_PASSB;
            default: aluControl = `ALU_ADD;
        endcase
    end

endmodule

// ==== control/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import rvcore_pkg::*; (
    input  instrWord    instr,
    input  logic        zero,
    ctrlIf.source       ctrl
);

    logic      branch;
    logic      jump;
    aluOpClass aluOp;

    mainDecoder mainDec (
        .instr     (instr),
        .regWrite  (ctrl.regWrite),
        .aluSrcImm (ctrl.aluSrcImm),
        .memWrite  (ctrl.memWrite),
        .branch    (branch),
        .jump      (jump),
        .resultSrc (ctrl.resultSrc),
        .immSrc    (ctrl.immSrc),
        .aluOp     (aluOp)
    );

    aluDecoder aluDec (
        .op5        (instr.R.opcode[5]),
        .funct75    (instr.R.funct7[5]),
        .funct3     (instr.R.funct3),
        .aluOp      (aluOp),
        .aluControl (ctrl.aluControl),
        .loadType   (ctrl.loadType)
    );

    // beq: a - b is zero, bge: a < b is false
    assign ctrl.pcSrc = jump | (branch & zero);

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module alu (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  logic [3:0]       aluControl,
    output logic [`XLEN-1:0] result,
    output logic             zero
);

    logic [4:0] shamt;
    logic       lessThan;

    assign shamt    = b[4:0];
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluControl)
            `ALU_ADD:   result = a + b;
            `ALU_SUB:   result = a - b;
            `ALU_AND:   result = a & b;
            `ALU_OR:    result = a | b;
            `ALU_XOR:   result = a ^ b;
            `ALU_SLL:   result = a << shamt;
            `ALU_SRL:   result = a >> shamt;
            `ALU_SRA:   result = $unsigned($signed(a) >>> shamt); // sign fill
            `ALU_SLT,
            `ALU_BCMP:  result = {{(`XLEN-1){1'b0}}, lessThan};
            `ALU_PASSB: result = b;
            default:    result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module regFile (
    input  logic             clk,
    input  logic             rstN,
    input  logic             writeEnable,
    input  logic [4:0]       readAddr1,
    input  logic [4:0]       readAddr2,
    input  logic [4:0]       writeAddr,
    input  logic [`XLEN-1:0] writeData,
    output logic [`XLEN-1:0] readData1,
    output logic [`XLEN-1:0] readData2
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end else if (writeEnable && (writeAddr != 5'd0)) begin
            regs[writeAddr] <= writeData; // x0 never written
        end
    end

    assign readData1 = regs[readAddr1];
    assign readData2 = regs[readAddr2];

endmodule

// ==== hdl/datapath.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module datapath import rvcore_pkg::*; (
    input  logic             clk,
    input  logic             rstN,
    ctrlIf.sink              ctrl,
    input  logic [31:0]      instrIn,
    output instrWord         instr,
    output logic             zero,
    output logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] aluResult,
    output logic [`XLEN-1:0] storeData,
    input  logic [`XLEN-1:0] readWord
);

    logic [`XLEN-1:0] pcPlus4;
    logic [`XLEN-1:0] pcTarget;
    logic [`XLEN-1:0] pcNext;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1Data;
    logic [`XLEN-1:0] rs2Data;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] shiftedWord;
    logic [`XLEN-1:0] loadData;
    logic [`XLEN-1:0] writeBack;

    assign instr = instrIn;

    // program counter
    assign pcPlus4  = pc + `XLEN'd4;
    assign pcTarget = pc + imm; // branch and jal target
    assign pcNext   = ctrl.pcSrc ? pcTarget : pcPlus4;

    always_ff @(posedge clk) begin
        if (!rstN)
            pc <= `RESET_PC;
        else
            pc <= pcNext;
    end

    // immediate generation, sign extended
    always_comb begin
        case (ctrl.immSrc)
            immI: imm = {{20{instr.I.imm[11]}}, instr.I.imm};
            immS: imm = {{20{instr.S.immHi[6]}}, instr.S.immHi, instr.S.immLo};
            immB: imm = {{20{instr.B.imm12}}, instr.B.imm11, instr.B.imm10to5,
                         instr.B.imm4to1, 1'b0};
            immU: imm = {instr.U.imm, 12'b0};
            immJ: imm = {{12{instr.J.imm20}}, instr.J.imm19to12, instr.J.imm11,
                         instr.J.imm10to1, 1'b0};
            default: imm = '0;
        endcase
    end

    regFile regs (
        .clk         (clk),
        .rstN        (rstN),
        .writeEnable (ctrl.regWrite),
        .readAddr1   (instr.R.rs1),
        .readAddr2   (instr.R.rs2),
        .writeAddr   (instr.R.rd),
        .writeData   (writeBack),
        .readData1   (rs1Data),
        .readData2   (rs2Data)
    );

    assign srcB = ctrl.aluSrcImm ? imm : rs2Data;

    alu aluUnit (
        .a          (rs1Data),
        .b          (srcB),
        .aluControl (ctrl.aluControl),
        .result     (aluResult),
        .zero       (zero)
    );

    assign storeData = rs2Data;

    // move the addressed byte down to bit 0
    assign shiftedWord = readWord >> {aluResult[1:0], 3'b000};

    always_comb begin
        case (ctrl.loadType)
            dtByteU: loadData = {24'b0, shiftedWord[7:0]};
            dtHalfU: loadData = {16'b0, shiftedWord[15:0]};
            default: loadData = readWord; // lw
        endcase
    end

    always_comb begin
        case (ctrl.resultSrc)
            resLoad:    writeBack = loadData;
            resPcPlus4: writeBack = pcPlus4;
            default:    writeBack = aluResult;
        endcase
    end

endmodule

// ==== hdl/rvcoreTop.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module rvcoreTop import rvcore_pkg::*; (
    input  logic             clk,
    input  logic             rstN,
    output logic [`XLEN-1:0] imemAddr,
    input  logic [31:0]      imemData,
    output logic [`XLEN-1:0] dmemAddr,
    output logic [`XLEN-1:0] dmemWriteData,
    output logic             dmemWrite,
    input  logic [`XLEN-1:0] dmemReadData
);

    instrWord instr;
    logic     zero;

    ctrlIf ctrlBus ();

    controlUnit control (
        .instr (instr),
        .zero  (zero),
        .ctrl  (ctrlBus.source)
    );

    datapath dp (
        .clk       (clk),
        .rstN      (rstN),
        .ctrl      (ctrlBus.sink),
        .instrIn   (imemData),
        .instr     (instr),
        .zero      (zero),
        .pc        (imemAddr),
        .aluResult (dmemAddr),
        .storeData (dmemWriteData),
        .readWord  (dmemReadData)
    );

    assign dmemWrite = ctrlBus.memWrite; // high only while a sw is at the pc

endmodule

// ==== verification/rvcore_asserts.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module rvcoreAsserts (
    input logic             clk,
    input logic             rstN,
    input logic             dmemWrite,
    input logic [`XLEN-1:0] imemAddr,
    input logic [`XLEN-1:0] regZero   // register file entry 0
);

    int failCount = 0; // summed into the testbench error count

    writeKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(dmemWrite))
        else begin
            failCount++;
            $error("dmemWrite is unknown while out of reset");
        end

    pcAligned: assert property (@(posedge clk) disable iff (!rstN) imemAddr[1:0] == 2'b00)
        else begin
            failCount++;
            $error("imemAddr is not word aligned");
        end

    zeroRegHeld: assert property (@(posedge clk) disable iff (!rstN) regZero == '0)
        else begin
            failCount++;
            $error("register x0 holds a nonzero value");
        end

endmodule

bind rvcoreTop rvcoreAsserts coreChecks (
    .clk       (clk),
    .rstN      (rstN),
    .dmemWrite (dmemWrite),
    .imemAddr  (imemAddr),
    .regZero   (dp.regs.regs[0])
);

// ==== verification/rvcore_tb.sv ====
`timescale 1ns/1ps
`include "rvcore_macros.svh"

module rvcore_tb;

    localparam int PROG_WORDS = 128;
    localparam int DATA_BASE = 'h080;
    localparam int DATA_WORDS = 4;
    localparam int COUNT_ADDR = 'h0A0;
    localparam int REC_BASE = 'h0A1; // records of id, address, value
    localparam int TIMEOUT_CYCLES = 500;
    localparam logic [31:0] HALT_PC = 32'h0000_010C; // final jal to itself

    logic             clk;
    logic             rstN;
    logic [`XLEN-1:0] imemAddr;
    logic [31:0]      imemData;
    logic [`XLEN-1:0] dmemAddr;
    logic [`XLEN-1:0] dmemWriteData;
    logic             dmemWrite;
    logic [`XLEN-1:0] dmemReadData;

    logic [31:0] testData [256];
    logic [31:0] instrMem [PROG_WORDS];
    logic [31:0] dataMem [256];

    int recCount;
    int recIndex;
    int checkCount;
    int errorCount;
    int groupChecks;
    int groupErrors;

    logic        pendWrite;
    logic [31:0] pendAddr;
    logic [31:0] pendData;

    rvcoreTop uut (
        .clk           (clk),
        .rstN          (rstN),
        .imemAddr      (imemAddr),
        .imemData      (imemData),
        .dmemAddr      (dmemAddr),
        .dmemWriteData (dmemWriteData),
        .dmemWrite     (dmemWrite),
        .dmemReadData  (dmemReadData)
    );

    always #4 clk = ~clk;

    // combinational memories
    assign imemData     = instrMem[imemAddr[8:2]];
    assign dmemReadData = dataMem[dmemAddr[9:2]];

    function automatic string testName(input int id);
        case (id)
            1: return "reset";
            2: return "arithmetic";
            3: return "shifts";
            4: return "loads";
            5: return "control flow";
            6: return "lui";
            default: return "unknown";
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        checkCount++;
        groupChecks++;
        if (actual !== expected) begin
            errorCount++;
            groupErrors++;
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
        end
    endtask

    task automatic reportGroup(input int id);
        $display("test %0d %s: %0d checks, %0d errors", id, testName(id), groupChecks,
                 groupErrors);
        groupChecks = 0;
        groupErrors = 0;
    endtask

    task automatic checkStore();
        int base;
        int id;
        base = REC_BASE + 3 * recIndex;
        if (recIndex >= recCount) begin
            errorCount++;
            $display("an extra store to address %h happened at %0t ns", dmemAddr, $time);
        end else begin
            id = testData[base];
            compareValue("dmemAddr", dmemAddr, testData[base + 1]);
            compareValue("dmemWriteData", dmemWriteData, testData[base + 2]);
            recIndex++;
            if (recIndex == recCount || testData[base + 3] != id)
                reportGroup(id); // last record of this group
        end
    endtask

    // store checker sampled mid cycle
    always @(negedge clk) begin
        pendWrite = 1'b0;
        if (rstN === 1'b1 && dmemWrite === 1'b1) begin
            pendWrite = 1'b1;
            pendAddr  = dmemAddr;
            pendData  = dmemWriteData;
            checkStore();
        end
    end

    always @(posedge clk) begin
        if (pendWrite)
            dataMem[pendAddr[9:2]] <= pendData;
    end

    initial begin
        int cycles;
        clk         = 1'b0;
        rstN        = 1'b0;
        pendWrite   = 1'b0;
        pendAddr    = '0;
        pendData    = '0;
        recIndex    = 0;
        checkCount  = 0;
        errorCount  = 0;
        groupChecks = 0;
        groupErrors = 0;
        $readmemh("verification/rvcore_testdata.txt", testData);
        for (int i = 0; i < PROG_WORDS; i++)
            instrMem[i] = testData[i];
        for (int i = 0; i < DATA_WORDS; i++)
            dataMem[i] = testData[DATA_BASE + i];
        if ($isunknown(testData[COUNT_ADDR])) begin
            errorCount++;
            recCount = 0;
            $display("the test data file could not be read");
        end else begin
            recCount = testData[COUNT_ADDR];
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // first cycle out of reset
        compareValue("imemAddr", imemAddr, `RESET_PC);
        compareValue("dmemWrite", {31'b0, dmemWrite}, 32'd0);
        reportGroup(1);

        cycles = 0;
        while (recIndex < recCount && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (recIndex < recCount) begin
            errorCount++;
            $display("timed out after %0d cycles with %0d of %0d stores seen", cycles,
                     recIndex, recCount);
        end else begin
            cycles = 0;
            while (imemAddr !== HALT_PC && cycles < 20) begin
                @(negedge clk);
                cycles++;
            end
            repeat (4) @(negedge clk); // any late store shows up here
            compareValue("imemAddr", imemAddr, HALT_PC);
        end

        if (uut.coreChecks.failCount != 0) begin
            errorCount += uut.coreChecks.failCount;
            $display("the bound checker reported %0d assertion failures",
                     uut.coreChecks.failCount);
        end

        $display("done: %0d checks, %0d errors, %0d of %0d stores seen", checkCount,
                 errorCount, recIndex, recCount);
        if (errorCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== rvcore.f ====
+incdir+common
common/rvcore_pkg.sv
common/ctrl_if.sv
control/mainDecoder.sv
control/aluDecoder.sv
control/controlUnit.sv
hdl/alu.sv
hdl/regFile.sv
hdl/datapath.sv
hdl/rvcoreTop.sv
verification/rvcore_asserts.sv
verification/rvcore_tb.sv

// ==== verification/rvcore_testdata.txt ====
// hex words: @000 program, @080 initial data, @0A0 number of store records
// @0A1 store records, one per line: test id, byte address, stored value
@000
08000513 06400093 FF900113 002081B3 00352023 40208233 00452223 0020F2B3
00552423 0020E333 00652623 0020C3B3 00752823 00112433 00852A23 0F017593
F000E613 7FF0C693 0320A713 40008793 00B52C23 00C52E23 02D52023 02E52223
02F52423 00400813 010118B3 01015933 410159B3 00811A13 01C15A93 40215B13
03152623 03252823 03352A23 03452C23 03552E23 05652023 00002B83 00004C03
00104C83 00204D03 00304D83 00005E03 00205E83 00402F03 05752223 05852423
05952623 05A52823 05B52A23 05C52C23 05D52E23 07E52023 00208463 06152223
00108463 06252423 0020D463 06252423 00115463 06352423 00800FEF 06252623
07F52623 ABCDE4B7 06952823 0000006F
@080
80F1A27C 12345678 0BADF00D 5A5AC3C3
@0A0
0000001D
00000002 00000080 0000005D
00000002 00000084 0000006B
00000002 00000088 00000060
00000002 0000008C FFFFFFFD
00000002 00000090 FFFFFF9D
00000002 00000094 00000001
00000002 00000098 000000F0
00000002 0000009C FFFFFF64
00000002 000000A0 0000079B
00000002 000000A4 00000000
00000002 000000A8 00000464
00000003 000000AC FFFFFF90
00000003 000000B0 0FFFFFFF
00000003 000000B4 FFFFFFFF
00000003 000000B8 FFFFF900
00000003 000000BC 0000000F
00000003 000000C0 FFFFFFFE
00000004 000000C4 80F1A27C
00000004 000000C8 0000007C
00000004 000000CC 000000A2
00000004 000000D0 000000F1
00000004 000000D4 00000080
00000004 000000D8 0000A27C
00000004 000000DC 000080F1
00000004 000000E0 12345678
00000005 000000E4 00000064
00000005 000000E8 0000005D
00000005 000000EC 000000FC
00000006 000000F0 ABCDE000
